// File: common/gpio_bus_pkg.sv
// shared widths, address map and wait counts; windows must stay 32-byte aligned for decoding

package gpio_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus and word geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int ADDR_W     = 32;                  // byte address
	localparam int DATA_W     = 32;                  // one bus word = one gpio word
	localparam int NUM_WORDS  = 8;                   // words per window
	localparam int WORD_IDX_W = $clog2(NUM_WORDS);   // 3 bits for 8 words
	localparam int GPIO_W     = NUM_WORDS * DATA_W;  // 256-bit gp_op / gp_ip

	// byte lane bits below the word index, must be zero on any access
	localparam int BYTE_OFF_W = $clog2(DATA_W / 8);
	// first address bit above a window
	localparam int WIN_LSB    = BYTE_OFF_W + WORD_IDX_W;

	////////////////////////////////////////////////////////////////////////////
	// address map
	////////////////////////////////////////////////////////////////////////////

	// output window, read/write, 0x0100_0000 .. 0x0100_001c
	localparam logic [ADDR_W-1:0] GPO_BASE = 32'h0100_0000;
	// input window, read only, 0x0100_0020 .. 0x0100_003c
	localparam logic [ADDR_W-1:0] GPI_BASE = 32'h0100_0020;

	////////////////////////////////////////////////////////////////////////////
	// fixed wait states
	////////////////////////////////////////////////////////////////////////////

	// cycles between the valid-sampling edge and the response edge, minus one
	localparam int WRITE_WAIT = 2;   // ready registered at edge 3
	localparam int READ_WAIT  = 3;   // ready registered at edge 4
	localparam int WAIT_CNT_W = 2;   // holds up to READ_WAIT

	////////////////////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////////////////////

	// what the decoder made of addr/rnw
	typedef enum logic [1:0] {
		REGION_GPO = 2'd0,   // output word, read or write
		REGION_GPI = 2'd1,   // input word, read only
		REGION_ERR = 2'd2    // unmapped, unaligned or write to input
	} region_e;

	// bus controller
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,      // waiting for valid
		ST_WAIT = 2'd1,      // counting wait states
		ST_RESP = 2'd2       // ready high this cycle
	} slave_state_e;

endpackage : gpio_bus_pkg

// File: rtl/gpio_addr_decode.sv
// purely combinational; addr and rnw must be held stable by the master for the whole transfer
`timescale 1ns/10ps

module gpio_addr_decode (
	input  logic [gpio_bus_pkg::ADDR_W-1:0]     addr,
	input  logic                                rnw,      // 1 = read
	output gpio_bus_pkg::region_e               region,
	output logic [gpio_bus_pkg::WORD_IDX_W-1:0] word_idx
);

	import gpio_bus_pkg::*;

	logic aligned;   // byte offset bits clear
	logic in_gpo;    // upper bits hit output window
	logic in_gpi;    // upper bits hit input window

	assign aligned = (addr[BYTE_OFF_W-1:0] == '0);
	assign in_gpo  = (addr[ADDR_W-1:WIN_LSB] == GPO_BASE[ADDR_W-1:WIN_LSB]);
	assign in_gpi  = (addr[ADDR_W-1:WIN_LSB] == GPI_BASE[ADDR_W-1:WIN_LSB]);

	// region select
	// unaligned anywhere is an error, even inside a window
	always_comb begin
		region = REGION_ERR;
		if (aligned) begin
			if (in_gpo) begin
				region = REGION_GPO;             // either direction
			end else if (in_gpi && rnw) begin
				region = REGION_GPI;             // reads only
			end
		end
	end

	// word within the window, same bits for both windows
	assign word_idx = addr[WIN_LSB-1:BYTE_OFF_W];

endmodule : gpio_addr_decode

// File: rtl/gpio_bus_ctrl.sv
// single outstanding transfer; response is not back-pressured, master must take it in its cycle
`timescale 1ns/10ps

module gpio_bus_ctrl (
	input  logic                                BUS_agnt_vi,
	input  logic                                rst_n,
	// bus request
	input  logic                                valid,
	input  logic                                rnw,
	input  logic [gpio_bus_pkg::ADDR_W-1:0]     addr,
	input  logic [gpio_bus_pkg::DATA_W-1:0]     write_data,
	// bus response
	output logic                                ready,
	output logic                                error,
	output logic [gpio_bus_pkg::DATA_W-1:0]     read_data,
	// to word bank
	output logic                                wr_en,
	output logic [gpio_bus_pkg::WORD_IDX_W-1:0] word_idx,
	output logic [gpio_bus_pkg::DATA_W-1:0]     wr_data,
	output gpio_bus_pkg::region_e               rd_region,
	input  logic [gpio_bus_pkg::DATA_W-1:0]     rd_data
);

	import gpio_bus_pkg::*;

	slave_state_e           state;
	logic [WAIT_CNT_W-1:0]  wait_cnt;    // counts down to the response edge
	region_e                dec_region;
	logic [WORD_IDX_W-1:0]  dec_idx;
	logic                   legal;       // access maps onto a real word
	logic                   last_wait;   // next edge registers the response

	////////////////////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////////////////////

	gpio_addr_decode u_decode (
		.addr     (addr),
		.rnw      (rnw),
		.region   (dec_region),
		.word_idx (dec_idx)
	);

	assign legal     = (dec_region != REGION_ERR);
	assign last_wait = (state == ST_WAIT) && (wait_cnt == '0);

	// write lands in the bank on the same edge that raises ready
	assign wr_en     = last_wait && !rnw && legal;
	assign word_idx  = dec_idx;
	assign wr_data   = write_data;
	assign rd_region = dec_region;   // bank returns zero for REGION_ERR

	////////////////////////////////////////////////////////////////////////////
	// FSM and registered response
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge BUS_agnt_vi) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			wait_cnt  <= '0;
			ready     <= 1'b0;
			error     <= 1'b0;
			read_data <= '0;
		end else begin
			// response fields are pulses, default low
			ready     <= 1'b0;
			error     <= 1'b0;
			read_data <= '0;
			case (state)
				ST_IDLE: begin
					if (valid) begin   // edge 1
						state <= ST_WAIT;
						// load wait count minus one, edge 1 already spent
						wait_cnt <= rnw ? WAIT_CNT_W'(READ_WAIT - 1)
						                : WAIT_CNT_W'(WRITE_WAIT - 1);
					end
				end
				ST_WAIT: begin
					if (wait_cnt == '0) begin   // edge 3 write, edge 4 read
						state <= ST_RESP;
						ready <= 1'b1;
						error <= !legal;
						if (rnw && legal) begin
							read_data <= rd_data;   // gp_ip sampled here
						end
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				ST_RESP: begin
					state <= ST_IDLE;   // valid still high here is the old request
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// protocol checks
	////////////////////////////////////////////////////////////////////////////

	// master holds the request until it has seen ready
	// response edge excluded, the next request may follow right after it
	a_req_stable: assert property (
		@(posedge BUS_agnt_vi) disable iff (!rst_n)
		(valid && !ready && !last_wait) |=> ($stable(addr) && $stable(rnw))
	) else $error("addr/rnw changed before ready");

	// one response cycle per transfer
	a_ready_pulse: assert property (
		@(posedge BUS_agnt_vi) disable iff (!rst_n)
		ready |=> !ready
	) else $error("ready high for two cycles");

endmodule : gpio_bus_ctrl

// File: rtl/gpio_word_bank.sv
// no legality check here, acts on wr_en/word_idx as given; gp_ip read without synchronisation
`timescale 1ns/10ps

module gpio_word_bank (
	input  logic                                BUS_agnt_vi,
	input  logic                                rst_n,
	// write side
	input  logic                                wr_en,
	input  logic [gpio_bus_pkg::WORD_IDX_W-1:0] word_idx,   // shared by read and write
	input  logic [gpio_bus_pkg::DATA_W-1:0]     wr_data,
	// read side
	input  gpio_bus_pkg::region_e               rd_region,
	output logic [gpio_bus_pkg::DATA_W-1:0]     rd_data,
	// gpio pins
	output logic [gpio_bus_pkg::GPIO_W-1:0]     gp_op,
	output logic [gpio_bus_pkg::NUM_WORDS-1:0]  gp_op_valid,  // one-cycle per-word strobe
	input  logic [gpio_bus_pkg::GPIO_W-1:0]     gp_ip
);

	import gpio_bus_pkg::*;

	logic [DATA_W-1:0] op_word [NUM_WORDS];   // output store, word 0 = gp_op[31:0]

	////////////////////////////////////////////////////////////////////////////
	// output store and update strobe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge BUS_agnt_vi) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_WORDS; i++) begin
				op_word[i] <= '0;   // gp_op reads zero out of reset
			end
			gp_op_valid <= '0;
		end else begin
			gp_op_valid <= '0;   // clean pulse, no sticky valid
			if (wr_en) begin
				op_word[word_idx]     <= wr_data;
				gp_op_valid[word_idx] <= 1'b1;
			end
		end
	end

	// flatten words onto the 256-bit output bus
	for (genvar g = 0; g < NUM_WORDS; g++) begin : g_pack
		assign gp_op[g*DATA_W +: DATA_W] = op_word[g];
	end

	////////////////////////////////////////////////////////////////////////////
	// read mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (rd_region)
			REGION_GPO: rd_data = op_word[word_idx];                  // read-back
			REGION_GPI: rd_data = gp_ip[word_idx*DATA_W +: DATA_W];   // live input
			default:    rd_data = '0;                                 // error reads zero
		endcase
	end

	// at most one word strobed per write
	a_valid_onehot: assert property (
		@(posedge BUS_agnt_vi) disable iff (!rst_n)
		$onehot0(gp_op_valid)
	) else $error("gp_op_valid not one-hot: %b", gp_op_valid);

endmodule : gpio_word_bank

// File: rtl/gpio_bus_slave.sv
// writes take three cycles and reads four from valid; no pipelining, one transfer at a time
`timescale 1ns/10ps

module gpio_bus_slave (
	input  logic                                BUS_agnt_vi,
	input  logic                                rst_n,
	// bus
	input  logic                                valid,
	input  logic                                rnw,
	input  logic [gpio_bus_pkg::ADDR_W-1:0]     addr,
	input  logic [gpio_bus_pkg::DATA_W-1:0]     write_data,
	output logic                                ready,
	output logic                                error,
	output logic [gpio_bus_pkg::DATA_W-1:0]     read_data,
	// gpio
	output logic [gpio_bus_pkg::GPIO_W-1:0]     gp_op,
	output logic [gpio_bus_pkg::NUM_WORDS-1:0]  gp_op_valid,
	input  logic [gpio_bus_pkg::GPIO_W-1:0]     gp_ip
);

	import gpio_bus_pkg::*;

	// controller to bank
	logic                  wr_en;
	logic [WORD_IDX_W-1:0] word_idx;
	logic [DATA_W-1:0]     wr_data;
	region_e               rd_region;
	logic [DATA_W-1:0]     rd_data;   // combinational back to controller

	gpio_bus_ctrl u_ctrl (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n       (rst_n),
		.valid       (valid),
		.rnw         (rnw),
		.addr        (addr),
		.write_data  (write_data),
		.ready       (ready),
		.error       (error),
		.read_data   (read_data),
		.wr_en       (wr_en),
		.word_idx    (word_idx),
		.wr_data     (wr_data),
		.rd_region   (rd_region),
		.rd_data     (rd_data)
	);

	gpio_word_bank u_bank (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.word_idx    (word_idx),
		.wr_data     (wr_data),
		.rd_region   (rd_region),
		.rd_data     (rd_data),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid),
		.gp_ip       (gp_ip)
	);

endmodule : gpio_bus_slave

// File: verification/gpio_bus_slave_tb.sv
// one transfer in flight; back-to-back entries are issued in the cycle right after ready
`timescale 1ns/10ps

module gpio_bus_slave_tb;

	import gpio_bus_pkg::*;

	localparam int CLK_NS      = 4;
	localparam int RST_CYCLES  = 10;
	localparam int TBL_LEN     = 35;                    // must match build_table
	localparam int WR_LAT      = 1 + WRITE_WAIT;        // edges from edge 1 to ready
	localparam int RD_LAT      = 1 + READ_WAIT;
	localparam int WATCHDOG_NS = TBL_LEN * 10 * CLK_NS + RST_CYCLES * CLK_NS;
	localparam logic [31:0] SEED = 32'hee27_a0de;

	typedef struct packed {
		logic        rnw;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        exp_err;
		logic        b2b;      // issued in the cycle right after the previous ready
	} entry_t;

	logic                  BUS_agnt_vi;
	logic                  rst_n;
	logic                  valid;
	logic                  rnw;
	logic [ADDR_W-1:0]     addr;
	logic [DATA_W-1:0]     write_data;
	logic                  ready;
	logic                  error;
	logic [DATA_W-1:0]     read_data;
	logic [GPIO_W-1:0]     gp_op;
	logic [NUM_WORDS-1:0]  gp_op_valid;
	logic [GPIO_W-1:0]     gp_ip;

	entry_t      tbl [TBL_LEN];
	int          n_entries;
	logic [31:0] rng;                    // xorshift state
	logic [31:0] model [NUM_WORDS];      // shadow of the output words

	gpio_bus_slave u_dut (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n       (rst_n),
		.valid       (valid),
		.rnw         (rnw),
		.addr        (addr),
		.write_data  (write_data),
		.ready       (ready),
		.error       (error),
		.read_data   (read_data),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid),
		.gp_ip       (gp_ip)
	);

	initial begin
		BUS_agnt_vi = 1'b0;
		forever #(CLK_NS / 2) BUS_agnt_vi = ~BUS_agnt_vi;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic in_gpi_window(input logic [31:0] a);
		return a[31:5] == GPI_BASE[31:5];   // 32-byte window
	endfunction

	function automatic logic [GPIO_W-1:0] pack_model();
		logic [GPIO_W-1:0] v;
		for (int w = 0; w < NUM_WORDS; w++) begin
			v[w*DATA_W +: DATA_W] = model[w];
		end
		return v;
	endfunction

	task automatic end_with_failure();
		$display("TB FAILED");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic check_value(input string name, input logic [GPIO_W-1:0] got,
		input logic [GPIO_W-1:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%0h exp 0x%0h", name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic add_entry(input logic r, input logic [31:0] a, input logic [31:0] d,
		input logic e, input logic b);
		tbl[n_entries] = '{rnw: r, addr: a, wdata: d, exp_err: e, b2b: b};
		n_entries++;
	endtask

	task automatic redraw_gp_ip();
		for (int w = 0; w < NUM_WORDS; w++) begin
			rng = xorshift32(rng);
			gp_ip[w*DATA_W +: DATA_W] = rng;
		end
	endtask

	task automatic build_table();
		n_entries = 0;
		for (int i = 0; i < NUM_WORDS; i++) begin   // fill output words
			rng = xorshift32(rng);
			add_entry(1'b0, GPO_BASE + 4 * i, rng, 1'b0, 1'b0);
		end
		for (int i = 0; i < NUM_WORDS; i++) add_entry(1'b1, GPO_BASE + 4 * i, '0, 1'b0, 1'b0);
		for (int i = 0; i < NUM_WORDS; i++) add_entry(1'b1, GPI_BASE + 4 * i, '0, 1'b0, 1'b0);
		// illegal accesses
		add_entry(1'b0, GPI_BASE + 32'h8, 32'hdead_beef, 1'b1, 1'b0);    // write to input
		add_entry(1'b0, 32'h0100_0044, 32'hcafe_f00d, 1'b1, 1'b0);      // past both windows
		add_entry(1'b1, GPI_BASE + 32'h20, '0, 1'b1, 1'b0);              // read off the end
		add_entry(1'b0, GPO_BASE + 32'h6, 32'h1234_5678, 1'b1, 1'b0);    // unaligned
		// back-to-back chain, new addr and direction on every request
		rng = xorshift32(rng);
		add_entry(1'b0, GPO_BASE + 32'h14, rng, 1'b0, 1'b0);
		rng = xorshift32(rng);
		add_entry(1'b0, GPO_BASE + 32'h18, rng, 1'b0, 1'b1);
		add_entry(1'b1, GPO_BASE + 32'h14, '0, 1'b0, 1'b1);
		add_entry(1'b1, GPI_BASE + 32'hc, '0, 1'b0, 1'b1);
		rng = xorshift32(rng);
		add_entry(1'b0, GPO_BASE + 32'h1c, rng, 1'b0, 1'b1);
		add_entry(1'b1, GPO_BASE + 32'h18, '0, 1'b0, 1'b1);
		add_entry(1'b0, GPI_BASE + 32'h4, 32'h0bad_0bad, 1'b1, 1'b1);   // error inside the chain
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus master
	////////////////////////////////////////////////////////////////////////////

	// called on a falling edge
	task automatic drive_request(input entry_t cur);
		valid      = 1'b1;
		rnw        = cur.rnw;
		addr       = cur.addr;
		write_data = cur.wdata;
		if (cur.rnw && in_gpi_window(cur.addr)) redraw_gp_ip();   // fresh pins per input read
	endtask

	// one edge with the controller back in idle, nothing may be pending
	task automatic idle_return_check();
		@(posedge BUS_agnt_vi);
		@(negedge BUS_agnt_vi);
		check_value("ready", ready, '0);
		check_value("gp_op_valid", gp_op_valid, '0);
	endtask

	// returns on the falling edge where ready is seen
	task automatic wait_response(input entry_t cur);
		int                   idx;
		int                   edges;
		int                   exp_lat;
		logic                 seen;
		logic [DATA_W-1:0]    exp_rdata;
		logic [NUM_WORDS-1:0] exp_strobe;
		idx        = cur.addr[4:2];
		exp_lat    = cur.rnw ? RD_LAT : WR_LAT;
		exp_rdata  = '0;   // errors and writes read zero
		exp_strobe = '0;
		if (!cur.exp_err) begin
			if (!cur.rnw) begin
				model[idx]      = cur.wdata;
				exp_strobe[idx] = 1'b1;
			end else if (in_gpi_window(cur.addr)) begin
				exp_rdata = gp_ip[idx*DATA_W +: DATA_W];
			end else begin
				exp_rdata = model[idx];
			end
		end
		if (cur.b2b) idle_return_check();   // edge after previous ready is not edge 1
		edges = 0;
		seen  = 1'b0;
		while (!seen && edges <= exp_lat) begin
			@(posedge BUS_agnt_vi);
			edges++;
			@(negedge BUS_agnt_vi);
			seen = ready;
			if (!seen) check_value("gp_op_valid", gp_op_valid, '0);   // no early strobe
		end
		if (!seen) begin
			$display("no ready from slave within %0d edges at addr 0x%0h", exp_lat, cur.addr);
			end_with_failure();
		end
		check_value("latency", edges, exp_lat);
		check_value("error", error, cur.exp_err);
		if (cur.rnw || cur.exp_err) check_value("read_data", read_data, exp_rdata);
		check_value("gp_op_valid", gp_op_valid, exp_strobe);
		check_value("gp_op", gp_op, pack_model());
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rng        = SEED;
		rst_n      = 1'b0;
		valid      = 1'b0;
		rnw        = 1'b0;
		addr       = '0;
		write_data = '0;
		gp_ip      = '0;
		for (int w = 0; w < NUM_WORDS; w++) model[w] = '0;
		build_table();
		if (n_entries != TBL_LEN) begin
			$display("stimulus table holds %0d entries, expected %0d", n_entries, TBL_LEN);
			end_with_failure();
		end
		repeat (RST_CYCLES) @(negedge BUS_agnt_vi);
		rst_n = 1'b1;
		repeat (2) begin   // quiet after reset
			@(posedge BUS_agnt_vi);
			@(negedge BUS_agnt_vi);
			check_value("gp_op", gp_op, '0);
			check_value("gp_op_valid", gp_op_valid, '0);
			check_value("ready", ready, '0);
			check_value("error", error, '0);
			check_value("read_data", read_data, '0);
		end
		for (int i = 0; i < TBL_LEN; i++) begin
			drive_request(tbl[i]);
			wait_response(tbl[i]);
			if (i == TBL_LEN - 1 || !tbl[i+1].b2b) begin
				valid = 1'b0;   // addr held, only valid drops
				idle_return_check();
			end
		end
		$display("TB PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, test did not finish", WATCHDOG_NS);
		end_with_failure();
	end

endmodule : gpio_bus_slave_tb

// File: build.f
common/gpio_bus_pkg.sv
rtl/gpio_addr_decode.sv
rtl/gpio_bus_ctrl.sv
rtl/gpio_word_bank.sv
rtl/gpio_bus_slave.sv
verification/gpio_bus_slave_tb.sv
